/* oled_setup_pkg.sv */
package oled_setup_pkg;

    ////////////////////////////////////////////////////////////
    // i2c bus engine state
    ////////////////////////////////////////////////////////////

    // state word coming from the external i2c engine
    // only START and ACKNOWLEDGE matter to the setup logic
    typedef enum logic [3:0] {
        IDLE            = 4'd0,
        // sda falls while scl is high
        START           = 4'd1,
        // slave address byte on the bus
        RECOGNITION     = 4'd2,
        WRITE_CONTROL   = 4'd3,
        WRITE_COMMAND   = 4'd4,
        WRITE_DATA      = 4'd5,
        READ            = 4'd6,
        // slave acks a control or command byte
        ACKNOWLEDGE     = 4'd7,
        // ack that follows the address byte only
        RECOGNITION_ACK = 4'd8,
        // sda rises while scl is high
        STOP            = 4'd9
    } bus_state_e;

    ////////////////////////////////////////////////////////////
    // control byte modes
    ////////////////////////////////////////////////////////////

    // mode held by the tracker, re-encoded into the control byte
    // single cmd -> 80h, multi cmd -> 00h
    // single data -> C0h, multi data -> 40h
    typedef enum logic [1:0] {
        CTRL_SINGLE_CMD  = 2'b00,
        CTRL_MULTI_CMD   = 2'b01,
        CTRL_SINGLE_DATA = 2'b10,
        CTRL_MULTI_DATA  = 2'b11
    } ctrl_mode_e;

    ////////////////////////////////////////////////////////////
    // init table
    ////////////////////////////////////////////////////////////

    // width of the command index from the sequencer
    localparam int CMD_INDEX_W = 5;

    // indexed entries, everything above falls back to NOP
    localparam int NUM_INIT_CMDS = 19;

    // one table entry
    // mode_load clear on parameter bytes, mode then stays as it was
    typedef struct packed {
        logic [7:0] cmd_byte;
        logic       mode_load;
        ctrl_mode_e mode;
    } cmd_entry_t;

    // continuation flag that goes with each entry
    typedef logic cmd_co_t;

    ////////////////////////////////////////////////////////////
    // address byte and output frame
    ////////////////////////////////////////////////////////////

    // address byte as it goes on the wire, or split into its fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [6:0] slave_addr;
            logic       read_write;
        } fields;
    } addr_byte_u;

    // everything the i2c engine needs for the next transfer
    typedef struct packed {
        logic [6:0] slave_addr;
        logic       read_write;
        logic [7:0] control_frame;
        logic [7:0] reg_addr;
        ctrl_mode_e control_select;
        logic       co_flag;
    } oled_frame_t;

    // 7-bit address of the display controller
    localparam logic [6:0] OLED_ADDR_DEFAULT = 7'h3C;

endpackage

/* oled_cmd_table.sv */
module oled_cmd_table
    import oled_setup_pkg::*;
(
    input  logic [CMD_INDEX_W-1:0] command_queue,
    output cmd_entry_t             entry,
    output cmd_co_t                entry_co
);

    // entry and its flag looked up together
    typedef struct packed {
        cmd_entry_t entry;
        cmd_co_t    co;
    } table_row_t;

    localparam logic LOAD = 1'b1;
    localparam logic KEEP = 1'b0;

    table_row_t row;
    logic       in_range;

    function automatic table_row_t make_row(
        input logic [7:0] cmd_byte,
        input logic       mode_load,
        input ctrl_mode_e mode,
        input cmd_co_t    co
    );
        table_row_t r;
        r.entry.cmd_byte  = cmd_byte;
        r.entry.mode_load = mode_load;
        r.entry.mode      = mode;
        r.co              = co;
        return r;
    endfunction

    assign in_range = (command_queue < NUM_INIT_CMDS);

    ////////////////////////////////////////////////////////////
    // power-up sequence
    ////////////////////////////////////////////////////////////

    always_comb begin
        // NOP, single command, flag set
        row = make_row(8'hE3, LOAD, CTRL_SINGLE_CMD, 1'b1);
        if (in_range) begin
            case (command_queue)
                // multiplex ratio, then its argument
                5'd0:  row = make_row(8'hA8, LOAD, CTRL_MULTI_CMD, 1'b0);
                5'd1:  row = make_row(8'h3F, KEEP, CTRL_SINGLE_CMD, 1'b1);
                // display offset
                5'd2:  row = make_row(8'hD3, LOAD, CTRL_MULTI_CMD, 1'b0);
                5'd3:  row = make_row(8'h00, KEEP, CTRL_SINGLE_CMD, 1'b1);
                // start line
                5'd4:  row = make_row(8'h40, LOAD, CTRL_SINGLE_CMD, 1'b1);
                // segment remap
                5'd5:  row = make_row(8'hA0, LOAD, CTRL_SINGLE_CMD, 1'b1);
                // com scan direction
                5'd6:  row = make_row(8'hC0, LOAD, CTRL_SINGLE_CMD, 1'b1);
                // com pin config
                5'd7:  row = make_row(8'hDA, LOAD, CTRL_MULTI_CMD, 1'b0);
                5'd8:  row = make_row(8'h02, KEEP, CTRL_SINGLE_CMD, 1'b1);
                // contrast
                5'd9:  row = make_row(8'h81, LOAD, CTRL_MULTI_CMD, 1'b0);
                5'd10: row = make_row(8'h7F, KEEP, CTRL_SINGLE_CMD, 1'b1);
                // display follows ram
                5'd11: row = make_row(8'hA4, LOAD, CTRL_SINGLE_CMD, 1'b1);
                // normal, not inverted
                5'd12: row = make_row(8'hA6, LOAD, CTRL_SINGLE_CMD, 1'b1);
                // oscillator freq and clock divide
                5'd13: row = make_row(8'hD5, LOAD, CTRL_MULTI_CMD, 1'b0);
                5'd14: row = make_row(8'h80, KEEP, CTRL_SINGLE_CMD, 1'b1);
                // charge pump on
                5'd15: row = make_row(8'h8D, LOAD, CTRL_MULTI_CMD, 1'b0);
                5'd16: row = make_row(8'h14, KEEP, CTRL_SINGLE_CMD, 1'b1);
                // panel on
                5'd17: row = make_row(8'hAF, LOAD, CTRL_SINGLE_CMD, 1'b1);
                // all pixels lit
                5'd18: row = make_row(8'hA5, LOAD, CTRL_SINGLE_CMD, 1'b1);
                default: begin
                    // keeps the NOP row
                end
            endcase
        end
    end

    // the mode field of a KEEP row is never loaded
    assign entry    = row.entry;
    assign entry_co = row.co;

endmodule

/* i2c_ctrl_tracker.sv */
module i2c_ctrl_tracker
    import oled_setup_pkg::*;
(
    input  logic       CLK,
    input  logic       NRST,
    input  logic       ack_strobe,
    input  cmd_entry_t entry,
    input  cmd_co_t    entry_co,
    output logic       phase,
    output ctrl_mode_e control_select,
    output logic       co_flag,
    output logic [7:0] control_frame
);

    // control byte value for each mode
    localparam logic [7:0] CTRL_BYTE_SINGLE_CMD  = 8'h80;
    localparam logic [7:0] CTRL_BYTE_MULTI_CMD   = 8'h00;
    localparam logic [7:0] CTRL_BYTE_SINGLE_DATA = 8'hC0;
    localparam logic [7:0] CTRL_BYTE_MULTI_DATA  = 8'h40;

    logic [7:0] ctrl_byte;

    ////////////////////////////////////////////////////////////
    // control byte encoding
    ////////////////////////////////////////////////////////////

    // works on the mode already held, not the incoming entry
    always_comb begin
        case (control_select)
            CTRL_SINGLE_CMD:  ctrl_byte = CTRL_BYTE_SINGLE_CMD;
            CTRL_MULTI_CMD:   ctrl_byte = CTRL_BYTE_MULTI_CMD;
            CTRL_SINGLE_DATA: ctrl_byte = CTRL_BYTE_SINGLE_DATA;
            CTRL_MULTI_DATA:  ctrl_byte = CTRL_BYTE_MULTI_DATA;
            default:          ctrl_byte = CTRL_BYTE_MULTI_CMD;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // frame step and mode registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            phase          <= 1'b0;
            // multi command until the table says otherwise
            control_select <= CTRL_MULTI_CMD;
            co_flag        <= 1'b0;
            control_frame  <= 8'h00;
        end else if (ack_strobe) begin
            // control byte refreshed on every ack, both phases
            control_frame <= ctrl_byte;
            if (!phase) begin
                // first ack of the pair sets up the control byte
                if (entry.mode_load) begin
                    control_select <= entry.mode;
                end
                co_flag <= entry_co;
            end
            // second ack hands the command byte to the builder
            phase <= ~phase;
        end
    end

endmodule

/* oled_frame_builder.sv */
module oled_frame_builder
    import oled_setup_pkg::*;
#(
    parameter logic [6:0] SLAVE_ADDR = OLED_ADDR_DEFAULT
) (
    input  logic        CLK,
    input  logic        NRST,
    input  bus_state_e  state,
    input  cmd_entry_t  entry,
    input  logic        phase,
    input  ctrl_mode_e  control_select,
    input  logic        co_flag,
    input  logic [7:0]  control_frame,
    output logic        ack_strobe,
    output oled_frame_t frame
);

    logic       start_hit;
    logic       cmd_load;
    addr_byte_u addr_next;
    addr_byte_u addr_q;
    logic [7:0] reg_addr_q;

    ////////////////////////////////////////////////////////////
    // bus state decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        start_hit  = 1'b0;
        ack_strobe = 1'b0;
        case (state)
            START:       start_hit  = 1'b1;
            ACKNOWLEDGE: ack_strobe = 1'b1;
            default: begin
                // remaining states just hold the registers
            end
        endcase
    end

    // command byte goes out on the second ack of a pair
    assign cmd_load = ack_strobe && phase;

    // address byte for a write, read is never issued
    always_comb begin
        addr_next.fields.slave_addr = SLAVE_ADDR;
        addr_next.fields.read_write = 1'b0;
    end

    ////////////////////////////////////////////////////////////
    // address and command registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            addr_q.raw <= 8'h00;
        end else if (start_hit) begin
            // stored as the byte that goes on the wire
            addr_q.raw <= addr_next.raw;
        end
    end

    always_ff @(posedge CLK) begin
        if (!NRST) begin
            reg_addr_q <= 8'h00;
        end else if (cmd_load) begin
            reg_addr_q <= entry.cmd_byte;
        end
    end

    ////////////////////////////////////////////////////////////
    // output frame
    ////////////////////////////////////////////////////////////

    always_comb begin
        frame.slave_addr     = addr_q.fields.slave_addr;
        frame.read_write     = addr_q.fields.read_write;
        frame.control_frame  = control_frame;
        frame.reg_addr       = reg_addr_q;
        frame.control_select = control_select;
        frame.co_flag        = co_flag;
    end

endmodule

/* oled_setup_top.sv */
module oled_setup_top
    import oled_setup_pkg::*;
#(
    parameter logic [6:0] SLAVE_ADDR = OLED_ADDR_DEFAULT
) (
    input  logic                   CLK,
    input  logic                   NRST,
    input  bus_state_e             state,
    input  logic [CMD_INDEX_W-1:0] command_queue,
    output oled_frame_t            frame
);

    // table lookup
    cmd_entry_t entry;
    cmd_co_t    entry_co;

    // tracker to builder
    logic       ack_strobe;
    logic       phase;
    ctrl_mode_e control_select;
    logic       co_flag;
    logic [7:0] control_frame;

    ////////////////////////////////////////////////////////////
    // instances
    ////////////////////////////////////////////////////////////

    oled_cmd_table table_i (
        .command_queue (command_queue),
        .entry         (entry),
        .entry_co      (entry_co)
    );

    // frame step, mode and control byte
    i2c_ctrl_tracker tracker_i (
        .CLK            (CLK),
        .NRST           (NRST),
        .ack_strobe     (ack_strobe),
        .entry          (entry),
        .entry_co       (entry_co),
        .phase          (phase),
        .control_select (control_select),
        .co_flag        (co_flag),
        .control_frame  (control_frame)
    );

    // state decode, address and command bytes
    oled_frame_builder #(
        .SLAVE_ADDR (SLAVE_ADDR)
    ) builder_i (
        .CLK            (CLK),
        .NRST           (NRST),
        .state          (state),
        .entry          (entry),
        .phase          (phase),
        .control_select (control_select),
        .co_flag        (co_flag),
        .control_frame  (control_frame),
        .ack_strobe     (ack_strobe),
        .frame          (frame)
    );

endmodule

/* tb_oled_model.svh */
`ifndef TB_OLED_MODEL_SVH
`define TB_OLED_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model of the setup sequencer
////////////////////////////////////////////////////////////

// address the dut is built with and the model expects
localparam logic [6:0] MODEL_ADDR = 7'h3C;

// model registers, the phase lives outside the frame
oled_frame_t m_frame;
logic        m_phase;

// one power-up table row as {cmd byte, mode load, mode, flag}
function automatic logic [11:0] ref_row(input logic [CMD_INDEX_W-1:0] idx);
    logic [11:0] row;
    case (idx)
        5'd0:    row = {8'hA8, 1'b1, 2'b01, 1'b0};
        5'd1:    row = {8'h3F, 1'b0, 2'b00, 1'b1};
        5'd2:    row = {8'hD3, 1'b1, 2'b01, 1'b0};
        5'd3:    row = {8'h00, 1'b0, 2'b00, 1'b1};
        5'd4:    row = {8'h40, 1'b1, 2'b00, 1'b1};
        5'd5:    row = {8'hA0, 1'b1, 2'b00, 1'b1};
        5'd6:    row = {8'hC0, 1'b1, 2'b00, 1'b1};
        5'd7:    row = {8'hDA, 1'b1, 2'b01, 1'b0};
        5'd8:    row = {8'h02, 1'b0, 2'b00, 1'b1};
        5'd9:    row = {8'h81, 1'b1, 2'b01, 1'b0};
        5'd10:   row = {8'h7F, 1'b0, 2'b00, 1'b1};
        5'd11:   row = {8'hA4, 1'b1, 2'b00, 1'b1};
        5'd12:   row = {8'hA6, 1'b1, 2'b00, 1'b1};
        5'd13:   row = {8'hD5, 1'b1, 2'b01, 1'b0};
        5'd14:   row = {8'h80, 1'b0, 2'b00, 1'b1};
        5'd15:   row = {8'h8D, 1'b1, 2'b01, 1'b0};
        5'd16:   row = {8'h14, 1'b0, 2'b00, 1'b1};
        5'd17:   row = {8'hAF, 1'b1, 2'b00, 1'b1};
        5'd18:   row = {8'hA5, 1'b1, 2'b00, 1'b1};
        // past the table: NOP in single command mode
        default: row = {8'hE3, 1'b1, 2'b00, 1'b1};
    endcase
    return row;
endfunction

// control byte for a mode
function automatic logic [7:0] ctrl_encode(input ctrl_mode_e mode);
    case (mode)
        CTRL_SINGLE_CMD:  return 8'h80;
        CTRL_MULTI_CMD:   return 8'h00;
        CTRL_SINGLE_DATA: return 8'hC0;
        default:          return 8'h40;
    endcase
endfunction

// frame right after reset
function automatic oled_frame_t reset_frame();
    oled_frame_t f;
    f                = '0;
    f.control_select = CTRL_MULTI_CMD;
    return f;
endfunction

// next expected frame after one rising edge
function automatic oled_frame_t ref_step(input oled_frame_t cur, input logic ph,
        input bus_state_e st, input logic [CMD_INDEX_W-1:0] idx);
    oled_frame_t nxt;
    logic [11:0] row;
    nxt = cur;
    row = ref_row(idx);
    if (st == START) begin
        nxt.slave_addr = MODEL_ADDR;
        nxt.read_write = 1'b0;
    end else if (st == ACKNOWLEDGE) begin
        // encoded from the mode held before this edge
        nxt.control_frame = ctrl_encode(cur.control_select);
        if (!ph) begin
            if (row[3]) begin
                nxt.control_select = ctrl_mode_e'(row[2:1]);
            end
            nxt.co_flag = row[0];
        end else begin
            nxt.reg_addr = row[11:4];
        end
    end
    return nxt;
endfunction

// frame step only moves on acknowledge
function automatic logic next_phase(input logic ph, input bus_state_e st);
    return (st == ACKNOWLEDGE) ? ~ph : ph;
endfunction

// 32-bit lcg
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
endfunction

`endif

/* tb_oled_setup.sv */
module tb_oled_setup
    import oled_setup_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int STIM_DELAY = 1;
    localparam int NUM_RANDOM = 240;
    // reset, idle checks, state sweep, table walk, nop range, random mix, tail
    localparam int TOTAL_CYCLES = 2 + 10 + 3 * NUM_INIT_CMDS
                                + 4 * (32 - NUM_INIT_CMDS) + NUM_RANDOM + 4;
    localparam int CYCLE_LIMIT = 2 * TOTAL_CYCLES;

    logic                   CLK;
    logic                   NRST;
    bus_state_e             state;
    logic [CMD_INDEX_W-1:0] command_queue;
    oled_frame_t            frame;

    int          mismatch_count;
    int          check_count;
    int          cycle_count;
    logic [31:0] rng;

    `include "tb_oled_model.svh"

    oled_setup_top #(
        .SLAVE_ADDR (MODEL_ADDR)
    ) dut_i (
        .CLK           (CLK),
        .NRST          (NRST),
        .state         (state),
        .command_queue (command_queue),
        .frame         (frame)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    // one bus cycle with the inputs moved just after the edge
    task automatic drive_cycle(input bus_state_e st, input logic [CMD_INDEX_W-1:0] idx);
        @(posedge CLK);
        #STIM_DELAY;
        state         = st;
        command_queue = idx;
    endtask

    task automatic compare_field(input string name, input logic [7:0] got,
            input logic [7:0] exp);
        check_count++;
        assert (got === exp) else begin
            mismatch_count++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_frame(input oled_frame_t exp);
        compare_field("slave_addr", frame.slave_addr, exp.slave_addr);
        compare_field("read_write", frame.read_write, exp.read_write);
        compare_field("control_frame", frame.control_frame, exp.control_frame);
        compare_field("reg_addr", frame.reg_addr, exp.reg_addr);
        compare_field("control_select", frame.control_select, exp.control_select);
        compare_field("co_flag", frame.co_flag, exp.co_flag);
    endtask

    ////////////////////////////////////////////////////////////
    // compare process
    ////////////////////////////////////////////////////////////

    // model follows the inputs seen at each edge and the frame is checked mid cycle
    initial begin : compare_proc
        bus_state_e             st_s;
        logic [CMD_INDEX_W-1:0] idx_s;
        logic                   rst_s;
        forever begin
            @(posedge CLK);
            st_s  = state;
            idx_s = command_queue;
            rst_s = NRST;
            if (!rst_s) begin
                m_frame = reset_frame();
                m_phase = 1'b0;
            end else begin
                m_frame = ref_step(m_frame, m_phase, st_s, idx_s);
                m_phase = next_phase(m_phase, st_s);
            end
            #(CLK_PERIOD / 2);
            check_frame(m_frame);
        end
    end

    // hard stop if the stimulus never ends
    initial begin : timeout_proc
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge CLK);
            cycle_count++;
        end
        $display("Run timed out after %0d clock cycles", cycle_count);
        $display("Test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin : stim_proc
        bus_state_e st;
        int         r;
        mismatch_count = 0;
        check_count    = 0;
        rng            = 32'd53;
        NRST           = 1'b0;
        state          = IDLE;
        command_queue  = '0;

        // two cycles in reset
        repeat (2) @(posedge CLK);
        #STIM_DELAY;
        NRST = 1'b1;

        // reset values hold while idle
        drive_cycle(IDLE, 5'd0);
        drive_cycle(IDLE, 5'd7);

        // start latches the address and other states hold everything
        drive_cycle(START, 5'd0);
        drive_cycle(RECOGNITION, 5'd3);
        drive_cycle(RECOGNITION_ACK, 5'd9);
        drive_cycle(WRITE_CONTROL, 5'd2);
        drive_cycle(WRITE_COMMAND, 5'd4);
        drive_cycle(WRITE_DATA, 5'd11);
        drive_cycle(READ, 5'd13);
        drive_cycle(STOP, 5'd20);

        // walk the table with two acks per entry
        for (int i = 0; i < NUM_INIT_CMDS; i++) begin
            drive_cycle(ACKNOWLEDGE, i[CMD_INDEX_W-1:0]);
            drive_cycle(WRITE_COMMAND, i[CMD_INDEX_W-1:0]);
            drive_cycle(ACKNOWLEDGE, i[CMD_INDEX_W-1:0])
            ;
        end

        // every index past the table gives NOP
        // entry 0 goes first so mode, flag and command byte all have to move
        for (int i = NUM_INIT_CMDS; i < 32; i++) begin
            drive_cycle(ACKNOWLEDGE, 5'd0);
            drive_cycle(ACKNOWLEDGE, 5'd0);
            drive_cycle(ACKNOWLEDGE, i[CMD_INDEX_W-1:0]);
            drive_cycle(ACKNOWLEDGE, i[CMD_INDEX_W-1:0]);
        end

        // random states with about half of them acknowledge
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rng = lcg_next(rng);
            r   = int'(rng[31:16]);
            if (r[3:0] < 4'd8) begin
                st = ACKNOWLEDGE;
            end else begin
                st = bus_state_e'(4'((r >> 4) % 10));
            end
            drive_cycle(st, 5'((r >> 8) % 24));
        end

        drive_cycle(IDLE, 5'd0);
        @(posedge CLK);
        // let the last check finish
        #(CLK_PERIOD / 2 + 1);

        $display("Checks: %0d, mismatches: %0d", check_count, mismatch_count);
        if (mismatch_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
oled_setup_pkg.sv
oled_cmd_table.sv
i2c_ctrl_tracker.sv
oled_frame_builder.sv
oled_setup_top.sv
tb_oled_setup.sv
